// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_sd_host
FILELIST  := tb.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test passed
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/sd_card_model.sv ====
`timescale 1ns/1ns

module sd_card_model import sd_host_pkg::*; (
  input  logic        i_sd_clk,
  inout  wire         io_sd_cmd,
  // Per command controls from the testbench
  input  logic        i_rsp_en,
  input  logic        i_bad_crc,
  // What the card saw
  output int          o_cmd_count,
  output int          o_bad_crc_count,
  output logic [5:0]  o_last_idx,
  output logic [31:0] o_last_arg
);

  logic      drv_en;
  logic      drv_bit;
  sd_frame_u cmd_rx;
  sd_frame_u rsp_tx;

  // Card side of the open CMD line
  assign io_sd_cmd = drv_en ? drv_bit : 1'bz;

  // CRC7 by long division with x^7 + x^3 + 1 over 40 message bits
  function automatic logic [6:0] crc7_div(input logic [39:0] msg);
    logic [46:0] rem;
    rem = {msg, 7'b0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) begin
        rem[i -: 8] = rem[i -: 8] ^ 8'h89;
      end
    end
    return rem[6:0];
  endfunction

  // Start bit already seen, collect the other 47 bits on rising edges
  task automatic receive_command();
    cmd_rx.raw[FRAME_BITS-1] = 1'b0;
    for (int i = FRAME_BITS - 2; i >= 0; i--) begin
      @(posedge i_sd_clk);
      cmd_rx.raw[i] = io_sd_cmd;
    end
    o_cmd_count = o_cmd_count + 1;
    o_last_idx  = cmd_rx.f.idx;
    o_last_arg  = cmd_rx.f.arg;
    // Host frames carry dir 1, a valid CRC and end bit 1
    if (cmd_rx.f.crc != crc7_div(cmd_rx.raw[47:8]) || !cmd_rx.f.dir_bit ||
        !cmd_rx.f.end_bit) begin
      o_bad_crc_count = o_bad_crc_count + 1;
    end
  endtask

  // R1 style answer, index echoed and argument inverted
  task automatic send_response();
    repeat (2) @(posedge i_sd_clk);
    rsp_tx.f = '{start_bit: 1'b0, dir_bit: 1'b0, idx: cmd_rx.f.idx,
                 arg: ~cmd_rx.f.arg, crc: 7'h00, end_bit: 1'b1};
    rsp_tx.f.crc = crc7_div(rsp_tx.raw[47:8]);
    if (i_bad_crc) begin
      rsp_tx.f.crc = ~rsp_tx.f.crc;
    end
    // Bits change on the falling card clock, MSB first
    for (int i = FRAME_BITS - 1; i >= 0; i--) begin
      @(negedge i_sd_clk);
      drv_en  = 1'b1;
      drv_bit = rsp_tx.raw[i];
    end
    @(negedge i_sd_clk);
    drv_en = 1'b0;
  endtask

  initial begin
    drv_en          = 1'b0;
    drv_bit         = 1'b1;
    o_cmd_count     = 0;
    o_bad_crc_count = 0;
    o_last_idx      = '0;
    o_last_arg      = '0;
    forever begin
      @(posedge i_sd_clk);
      // Idle line is pulled high, a low bit opens a command
      if (io_sd_cmd === 1'b0) begin
        receive_command();
        if (i_rsp_en) begin
          send_response();
        end
      end
    end
  end

endmodule

// ==== sim/tb_sd_host.sv ====
`timescale 1ns/1ns

module tb_sd_host import sd_host_pkg::*; ();

  // One table row, expected STATUS written out per row
  typedef struct packed {
    logic [5:0]  idx;
    logic [31:0] arg;
    logic        rsp_exp;
    logic        answer;
    logic        bad_crc;
    logic [31:0] exp_status;
  } row_t;

  localparam int NUM_ROWS = 6;
  // Arg 0 means draw a random argument
  // DONE|LOCKED = 0x12, plus CRC_ERR = 0x16, plus TIMEOUT = 0x1A
  localparam row_t ROW_TABLE [NUM_ROWS] = '{
    '{6'd17, 32'h0000_1234, 1'b1, 1'b1, 1'b0, 32'h0000_0012},
    '{6'd8,  32'h0000_0000, 1'b1, 1'b1, 1'b0, 32'h0000_0012},
    '{6'd0,  32'h0000_0000, 1'b0, 1'b0, 1'b0, 32'h0000_0012},
    '{6'd55, 32'h0000_0000, 1'b1, 1'b1, 1'b1, 32'h0000_0016},
    '{6'd13, 32'hdead_beef, 1'b1, 1'b0, 1'b0, 32'h0000_001A},
    '{6'd41, 32'h0000_0000, 1'b1, 1'b1, 1'b0, 32'h0000_0012}
  };
  localparam int RESET_NS = 10 * 10 + 400;
  localparam int ROW_NS   = (96 + 2 * RESP_TIMEOUT + 120) * 10;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        sd_clk;
  wire         sd_cmd;
  logic        card_rsp_en;
  logic        card_bad_crc;
  int          card_cmds;
  int          card_bad;
  logic [5:0]  card_idx;
  logic [31:0] card_arg;
  logic        sd_clk_check;
  logic        sd_clk_prev;
  int          errors;
  int          checks;
  logic [31:0] rng;

  // Board pull-up on CMD
  pullup (sd_cmd);

  sd_host_top uut (
    .clk       (clk),
    .rst       (rst),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr),
    .o_sd_clk  (sd_clk),
    .io_sd_cmd (sd_cmd)
  );

  sd_card_model u_card (
    .i_sd_clk        (sd_clk),
    .io_sd_cmd       (sd_cmd),
    .i_rsp_en        (card_rsp_en),
    .i_bad_crc       (card_bad_crc),
    .o_cmd_count     (card_cmds),
    .o_bad_crc_count (card_bad),
    .o_last_idx      (card_idx),
    .o_last_arg      (card_arg)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    assert (got === exp) else begin
      errors = errors + 1;
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Setup then access phase, outputs sampled mid access phase
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    check_eq("pready", 32'(pready), 32'd1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused_rd;
    apb_access(1'b1, addr, data, unused_rd, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'h0, data, err);
    check_eq("read pslverr", 32'(err), 32'd0);
  endtask

  // Poll STATUS until DONE, the watchdog bounds the loop
  task automatic wait_for_done(output logic [31:0] status);
    do begin
      apb_read(REG_STATUS, status);
    end while (!status[DONE]);
  endtask

  // Card clock must toggle on every clk cycle while a command runs
  always @(negedge clk) begin
    if (sd_clk_check) begin
      checks = checks + 1;
      assert (sd_clk != sd_clk_prev) else begin
        errors = errors + 1;
        $display("ERROR %0t: card clock held its value for a clk cycle", $time);
      end
    end
    sd_clk_prev <= sd_clk;
  end

  initial begin
    #(RESET_NS + (NUM_ROWS + 2) * ROW_NS);
    $display("Watchdog expired, a command never completed");
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] arg;
    logic        err;
    int          seen;
    row_t        row;

    rst          = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    card_rsp_en  = 1'b0;
    card_bad_crc = 1'b0;
    sd_clk_check = 1'b0;
    sd_clk_prev  = 1'b0;
    errors       = 0;
    checks       = 0;
    rng          = 32'h4c2f;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // Lock settles 16 cycles after reset, commands refused until then
    apb_read(REG_STATUS, rd);
    check_eq("LOCKED right after reset", 32'(rd[LOCKED]), 32'd0);
    apb_write(REG_CMD, 32'h0000_0111, err);
    check_eq("pslverr on CMD before lock", 32'(err), 32'd1);
    apb_read(REG_STATUS, rd);
    check_eq("BUSY after refused CMD", 32'(rd[BUSY]), 32'd0);
    repeat (16) @(posedge clk);
    apb_read(REG_STATUS, rd);
    check_eq("LOCKED after settling", 32'(rd[LOCKED]), 32'd1);
    check_eq("card commands before lock", card_cmds, 32'd0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      row = ROW_TABLE[r];
      arg = row.arg;
      if (arg == 32'h0) begin
        rng = xorshift32(rng);
        arg = rng;
      end
      card_rsp_en  = row.answer;
      card_bad_crc = row.bad_crc;
      seen         = card_cmds;
      $display("Row %0d: CMD%0d arg %h", r, row.idx, arg);
      apb_write(REG_ARG, arg, err);
      apb_write(REG_CMD, {23'h0, row.rsp_exp, 2'b00, row.idx}, err);
      check_eq("pslverr on accepted CMD", 32'(err), 32'd0);
      sd_clk_check = 1'b1;
      wait_for_done(rd);
      sd_clk_check = 1'b0;
      check_eq("STATUS", rd, row.exp_status);
      // Echoed index and inverted argument from the card
      if (row.rsp_exp && row.answer) begin
        apb_read(REG_RESP_IDX, rd);
        check_eq("RESP_IDX", rd, {26'h0, row.idx});
        apb_read(REG_RESP_ARG, rd);
        check_eq("RESP_ARG", rd, ~arg);
      end
      check_eq("card command count", card_cmds, seen + 1);
      check_eq("card saw index", 32'(card_idx), 32'(row.idx));
      check_eq("card saw argument", card_arg, arg);
      check_eq("card bad command CRCs", card_bad, 32'd0);
    end

    // Second CMD while busy is refused and leaves the first result alone
    rng          = xorshift32(rng);
    arg          = rng;
    card_rsp_en  = 1'b1;
    card_bad_crc = 1'b0;
    seen         = card_cmds;
    apb_write(REG_ARG, arg, err);
    apb_write(REG_CMD, 32'h0000_0109, err);
    check_eq("pslverr on first CMD", 32'(err), 32'd0);
    apb_write(REG_CMD, 32'h0000_0103, err);
    check_eq("pslverr on CMD while busy", 32'(err), 32'd1);
    wait_for_done(rd);
    check_eq("STATUS after refused CMD", rd, 32'h0000_0012);
    apb_read(REG_RESP_IDX, rd);
    check_eq("RESP_IDX after refused CMD", rd, 32'd9);
    apb_read(REG_RESP_ARG, rd);
    check_eq("RESP_ARG after refused CMD", rd, ~arg);
    check_eq("card commands with one refused", card_cmds, seen + 1);
    check_eq("card bad command CRCs", card_bad, 32'd0);

    $display("Summary: %0d checks, %0d errors, %0d bad command CRCs", checks, errors, card_bad);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
verilog/sd_host_pkg.sv
verilog/sd_host_platform.sv
verilog/sd_cmd_engine.sv
verilog/sd_host_apb_regs.sv
verilog/sd_host_top.sv
sim/sd_card_model.sv
sim/tb_sd_host.sv

// ==== verilog/sd_cmd_engine.sv ====
`timescale 1ns/1ns

module sd_cmd_engine import sd_host_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  // Request side
  input  logic     i_start,
  input  cmd_req_t i_req,
  // Card clock edge ticks from the platform
  input  logic     i_tick_rise,
  input  logic     i_tick_fall,
  // CMD line
  input  logic     i_cmd_in,
  output logic     o_cmd_dir,
  output logic     o_cmd_out,
  // Result side
  output logic     o_busy,
  output logic     o_done,
  output cmd_rsp_t o_rsp
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND,
    ST_WAIT,
    ST_RECV,
    ST_FINISH
  } state_t;

  state_t     state;
  cmd_req_t   req_q;
  sd_frame_u  tx;
  sd_frame_u  rx;
  sd_frame_u  rx_next;
  logic [5:0] bit_cnt;
  logic [6:0] tmo_cnt;
  logic [6:0] crc;
  logic [6:0] crc_next;
  logic       tx_bit;
  logic       crc_bit;

  // Current outgoing bit, bit_cnt 0 is the start bit
  assign tx_bit = tx.raw[6'(FRAME_BITS - 1) - bit_cnt];

  // Receive shift with the bit sampled this tick
  assign rx_next.raw = {rx.raw[FRAME_BITS-2:0], i_cmd_in};

  // One CRC register serves both directions
  assign crc_bit  = (state == ST_SEND) ? tx_bit : i_cmd_in;
  assign crc_next = crc7_next(crc, crc_bit);

  assign o_busy = (state != ST_IDLE);
  assign o_done = (state == ST_FINISH);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      o_cmd_dir <= 1'b0;
      o_cmd_out <= 1'b1;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_start) begin
            req_q   <= i_req;
            // Host to card frame, CRC filled in while shifting
            tx.f    <= '{start_bit: 1'b0, dir_bit: 1'b1, idx: i_req.idx,
                         arg: i_req.arg, crc: 7'h00, end_bit: 1'b1};
            bit_cnt <= '0;
            crc     <= '0;
            state   <= ST_SEND;
          end
        end

        ST_SEND: begin
          // CMD changes only as the card clock falls
          if (i_tick_fall) begin
            o_cmd_dir <= 1'b1;
            o_cmd_out <= tx_bit;
            // CRC covers start, dir, index and argument
            if (bit_cnt < 6'd40) begin
              crc <= crc_next;
            end
            // Last covered bit goes out, so the CRC is final
            if (bit_cnt == 6'd39) begin
              tx.f.crc <= crc_next;
            end
            if (bit_cnt == 6'(FRAME_BITS - 1)) begin
              // Response CRC starts again from zero
              crc     <= '0;
              tmo_cnt <= '0;
              state   <= ST_WAIT;
            end else begin
              bit_cnt <= bit_cnt + 6'd1;
            end
          end
        end

        ST_WAIT: begin
          // Hold the end bit for one card clock, then release
          if (i_tick_fall) begin
            o_cmd_dir <= 1'b0;
          end
          if (!req_q.rsp_exp) begin
            // No response, finish after two card clocks
            if (i_tick_fall) begin
              if (tmo_cnt == 7'd1) begin
                o_rsp <= '0;
                state <= ST_FINISH;
              end else begin
                tmo_cnt <= tmo_cnt + 7'd1;
              end
            end
          end else if (i_tick_rise) begin
            if (!o_cmd_dir && !i_cmd_in) begin
              // Start bit seen, it is bit 0 of the response
              crc     <= crc_next;
              rx.raw  <= rx_next.raw;
              bit_cnt <= 6'd1;
              state   <= ST_RECV;
            end else if (tmo_cnt == 7'(RESP_TIMEOUT - 1)) begin
              o_rsp.crc_err <= 1'b0;
              o_rsp.timeout <= 1'b1;
              o_rsp.idx     <= '0;
              o_rsp.arg     <= '0;
              state         <= ST_FINISH;
            end else begin
              tmo_cnt <= tmo_cnt + 7'd1;
            end
          end
        end

        ST_RECV: begin
          // Sample on the rising card clock
          if (i_tick_rise) begin
            rx.raw <= rx_next.raw;
            if (bit_cnt < 6'd40) begin
              crc <= crc_next;
            end
            if (bit_cnt == 6'(FRAME_BITS - 1)) begin
              // Received CRC field against the CRC of the first 40 bits
              o_rsp.crc_err <= (rx_next.f.crc != crc);
              o_rsp.timeout <= 1'b0;
              o_rsp.idx     <= rx_next.f.idx;
              o_rsp.arg     <= rx_next.f.arg;
              state         <= ST_FINISH;
            end else begin
              bit_cnt <= bit_cnt + 6'd1;
            end
          end
        end

        ST_FINISH: begin
          // One cycle done pulse, result is already in o_rsp
          state <= ST_IDLE;
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== verilog/sd_host_apb_regs.sv ====
`timescale 1ns/1ns

module sd_host_apb_regs import sd_host_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  // APB slave
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [7:0]  i_paddr,
  input  logic [31:0] i_pwdata,
  output logic [31:0] o_prdata,
  output logic        o_pready,
  output logic        o_pslverr,
  // Platform and engine
  input  logic        i_locked,
  input  logic        i_busy,
  input  logic        i_done,
  input  cmd_rsp_t    i_rsp,
  output logic        o_start,
  output cmd_req_t    o_req
);

  logic [31:0] arg_q;
  logic        done_q;
  cmd_rsp_t    rsp_q;
  logic [31:0] status;
  logic        access;
  logic        cmd_wr;
  logic        cmd_refuse;

  // Zero wait states, every access phase completes
  assign access   = i_psel & i_penable;
  assign o_pready = access;

  assign cmd_wr = access & i_pwrite & (i_paddr == REG_CMD);
  // Busy or not yet locked, also covers the cycle the start is in flight
  assign cmd_refuse = i_busy | o_start | ~i_locked;
  assign o_pslverr  = cmd_wr & cmd_refuse;

  always_comb begin
    status          = '0;
    status[BUSY]    = i_busy | o_start;
    status[DONE]    = done_q;
    status[CRC_ERR] = rsp_q.crc_err;
    status[TIMEOUT] = rsp_q.timeout;
    status[LOCKED]  = i_locked;
  end

  // Read mux, unmapped offsets read as zero
  always_comb begin
    case (i_paddr)
      REG_ARG:      o_prdata = arg_q;
      REG_CMD:      o_prdata = {23'h0, o_req.rsp_exp, 2'b00, o_req.idx};
      REG_STATUS:   o_prdata = status;
      REG_RESP_ARG: o_prdata = rsp_q.arg;
      REG_RESP_IDX: o_prdata = {26'h0, rsp_q.idx};
      default:      o_prdata = '0;
    endcase
  end

  // Argument is plain storage
  always_ff @(posedge clk) begin
    if (access && i_pwrite && i_paddr == REG_ARG) begin
      arg_q <= i_pwdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_start <= 1'b0;
      o_req   <= '0;
      done_q  <= 1'b0;
      rsp_q   <= '0;
    end else begin
      o_start <= 1'b0;
      if (cmd_wr && !cmd_refuse) begin
        // Index in 5:0, response flag in 8
        o_start       <= 1'b1;
        o_req.idx     <= i_pwdata[5:0];
        o_req.rsp_exp <= i_pwdata[8];
        o_req.arg     <= arg_q;
        done_q        <= 1'b0;
      end
      // Capture the engine result with its done pulse
      if (i_done) begin
        done_q <= 1'b1;
        rsp_q  <= i_rsp;
      end
    end
  end

endmodule

// ==== verilog/sd_host_pkg.sv ====
package sd_host_pkg;

  // CRC7 generator x^7 + x^3 + 1, x^7 implied
  localparam logic [6:0] CRC7_POLY = 7'h09;
  localparam int FRAME_BITS = 48;
  // Card clocks from command end bit to response start bit
  localparam int RESP_TIMEOUT = 64;
  // Platform settling count in clk cycles
  localparam int LOCK_COUNT = 15;

  // APB register map
  localparam logic [7:0] REG_ARG      = 8'h00;
  localparam logic [7:0] REG_CMD      = 8'h04;
  localparam logic [7:0] REG_STATUS   = 8'h08;
  localparam logic [7:0] REG_RESP_ARG = 8'h0C;
  localparam logic [7:0] REG_RESP_IDX = 8'h10;

  // STATUS bit positions
  localparam int BUSY    = 0;
  localparam int DONE    = 1;
  localparam int CRC_ERR = 2;
  localparam int TIMEOUT = 3;
  localparam int LOCKED  = 4;

  // One CMD frame, MSB first on the line
  typedef struct packed {
    logic        start_bit;
    logic        dir_bit;
    logic [5:0]  idx;
    logic [31:0] arg;
    logic [6:0]  crc;
    logic        end_bit;
  } sd_frame_t;

  // Same word seen as a shift register or as fields
  typedef union packed {
    logic [FRAME_BITS-1:0] raw;
    sd_frame_t             f;
  } sd_frame_u;

  typedef struct packed {
    logic [5:0]  idx;
    logic [31:0] arg;
    logic        rsp_exp;
  } cmd_req_t;

  typedef struct packed {
    logic        crc_err;
    logic        timeout;
    logic [5:0]  idx;
    logic [31:0] arg;
  } cmd_rsp_t;

  // One serial CRC7 step, feedback is the input bit xor the top bit
  function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic b);
    logic fb;
    fb = b ^ crc[6];
    return {crc[5:0], 1'b0} ^ (fb ? CRC7_POLY : 7'h00);
  endfunction

endpackage

// ==== verilog/sd_host_platform.sv ====
`timescale 1ns/1ns

module sd_host_platform import sd_host_pkg::*; (
  input  logic clk,
  input  logic rst,
  // Engine side
  input  logic i_cmd_dir,
  input  logic i_cmd_out,
  output logic o_cmd_in,
  output logic o_sd_clk,
  output logic o_sd_tick_rise,
  output logic o_sd_tick_fall,
  output logic o_locked,
  // Card side
  inout  wire  io_sd_cmd
);

  logic [3:0] lock_count;

  // Drive CMD only while the engine owns the line
  assign io_sd_cmd = i_cmd_dir ? i_cmd_out : 1'bz;
  // Pull-up on the board makes a released line read high
  assign o_cmd_in  = io_sd_cmd;

  // Card clock is clk / 2, so the next edge is known one cycle early
  // Low now means it rises at the coming clk edge
  assign o_sd_tick_rise = ~o_sd_clk;
  assign o_sd_tick_fall = o_sd_clk;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_sd_clk   <= 1'b0;
      lock_count <= '0;
      o_locked   <= 1'b0;
    end else begin
      o_sd_clk <= ~o_sd_clk;
      // Settle for LOCK_COUNT cycles, then hold lock
      if (lock_count < 4'(LOCK_COUNT)) begin
        lock_count <= lock_count + 4'd1;
      end else begin
        o_locked <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/sd_host_top.sv ====
`timescale 1ns/1ns

module sd_host_top import sd_host_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  // APB
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [7:0]  i_paddr,
  input  logic [31:0] i_pwdata,
  output logic [31:0] o_prdata,
  output logic        o_pready,
  output logic        o_pslverr,
  // Card pins
  output logic        o_sd_clk,
  inout  wire         io_sd_cmd
);

  cmd_req_t req;
  cmd_rsp_t rsp;
  logic     start;
  logic     busy;
  logic     done;
  logic     locked;
  logic     tick_rise;
  logic     tick_fall;
  logic     cmd_dir;
  logic     cmd_out;
  logic     cmd_in;

  // Software facing registers
  sd_host_apb_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr),
    .i_locked  (locked),
    .i_busy    (busy),
    .i_done    (done),
    .i_rsp     (rsp),
    .o_start   (start),
    .o_req     (req)
  );

  // CMD line protocol
  sd_cmd_engine u_engine (
    .clk         (clk),
    .rst         (rst),
    .i_start     (start),
    .i_req       (req),
    .i_tick_rise (tick_rise),
    .i_tick_fall (tick_fall),
    .i_cmd_in    (cmd_in),
    .o_cmd_dir   (cmd_dir),
    .o_cmd_out   (cmd_out),
    .o_busy      (busy),
    .o_done      (done),
    .o_rsp       (rsp)
  );

  // Card clock, lock and pin buffer
  sd_host_platform u_platform (
    .clk            (clk),
    .rst            (rst),
    .i_cmd_dir      (cmd_dir),
    .i_cmd_out      (cmd_out),
    .o_cmd_in       (cmd_in),
    .o_sd_clk       (o_sd_clk),
    .o_sd_tick_rise (tick_rise),
    .o_sd_tick_fall (tick_fall),
    .o_locked       (locked),
    .io_sd_cmd      (io_sd_cmd)
  );

endmodule
